// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // Datapath and address width
    localparam int NBITS = 32;

    // Instruction memory geometry
    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = 6;

    // Fetch queue depth, also the initial credit count
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = 2;           // Queue pointer width
    localparam int CREDIT_W    = 3;           // Holds 0 to QUEUE_DEPTH

    localparam logic [NBITS-1:0] RESET_PC = '0;
    localparam logic [NBITS-1:0] PC_STEP  = 32'd4;

    // MIPS field widths
    localparam int OPCODE_W = 6;
    localparam int REG_W    = 5;
    localparam int FUNCT_W  = 6;
    localparam int IMM_W    = 16;
    localparam int JIDX_W   = 26;

    // Opcodes that select the instruction kind
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL = 6'h00;  // R type
    localparam logic [OPCODE_W-1:0] OPC_J       = 6'h02;
    localparam logic [OPCODE_W-1:0] OPC_JAL     = 6'h03;

    // Fetched word paired with its address
    typedef struct packed {
        logic [NBITS-1:0] pc;
        logic [NBITS-1:0] instr;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        KIND_R = 2'd0,
        KIND_I = 2'd1,
        KIND_J = 2'd2
    } instr_kind_t;

    typedef struct packed {
        logic [NBITS-1:0]    pc;
        logic [NBITS-1:0]    instr;
        logic [OPCODE_W-1:0] opcode;
        logic [REG_W-1:0]    rs;
        logic [REG_W-1:0]    rt;
        logic [REG_W-1:0]    rd;
        logic [REG_W-1:0]    shamt;
        logic [FUNCT_W-1:0]  funct;
        logic [IMM_W-1:0]    imm;
        logic [JIDX_W-1:0]   jump_index;
        instr_kind_t         kind;
    } decoded_instr_t;

endpackage

// ==== hdl/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer
    import fetch_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_step,
    input  logic             i_redirect,        // Jump taken this cycle
    input  logic [NBITS-1:0] i_eff_addr,        // Jump target
    input  logic             i_credit_return,   // One slot freed in the queue
    input  logic [NBITS-1:0] i_imem_data,
    output logic             o_fetch_req,
    output logic [NBITS-1:0] o_fetch_pc,
    output fetch_entry_t     o_resp,
    output logic             o_resp_valid,
    output logic [NBITS-1:0] o_cycle_count
);

    logic [NBITS-1:0]    pc_q;
    logic [NBITS-1:0]    pc_next;
    logic [CREDIT_W-1:0] credit_cnt;
    logic [CREDIT_W-1:0] credit_next;
    logic                req_q;             // Read in flight
    logic [NBITS-1:0]    req_pc_q;          // Address of the read in flight
    logic [NBITS-1:0]    cycle_q;

    assign o_fetch_req = i_step && (credit_cnt != '0) && !i_redirect;
    assign o_fetch_pc  = pc_q;

    // Jump wins over the sequential step
    always_comb begin
        pc_next = pc_q;
        if (i_redirect) begin
            pc_next = i_eff_addr;
        end else if (o_fetch_req) begin
            pc_next = pc_q + PC_STEP;
        end
    end

    always_comb begin
        credit_next = credit_cnt;
        if (o_fetch_req) begin
            credit_next = credit_next - CREDIT_W'(1);
        end
        if (i_credit_return) begin
            credit_next = credit_next + CREDIT_W'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q       <= RESET_PC;
            credit_cnt <= CREDIT_W'(QUEUE_DEPTH);
            req_q      <= 1'b0;
            cycle_q    <= '0;
        end else begin
            pc_q  <= pc_next;
            req_q <= o_fetch_req;
            if (i_redirect) begin
                credit_cnt <= CREDIT_W'(QUEUE_DEPTH);  // Queue and in-flight read dropped
            end else begin
                credit_cnt <= credit_next;
            end
            if (i_step) begin
                cycle_q <= cycle_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_fetch_req) begin
            req_pc_q <= pc_q;
        end
    end

    // Memory data lands one cycle after the request
    assign o_resp.pc     = req_pc_q;
    assign o_resp.instr  = i_imem_data;
    assign o_resp_valid  = req_q && !i_redirect;  // Stale read on jump
    assign o_cycle_count = cycle_q;

    // Queue never returns a credit that was not spent
    a_credit_range: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_redirect && i_credit_return && !o_fetch_req |-> credit_cnt < CREDIT_W'(QUEUE_DEPTH));

    a_credit_bound: assert property (@(posedge i_clk) disable iff (i_reset)
        ##1 credit_cnt <= CREDIT_W'(QUEUE_DEPTH));

endmodule

// ==== hdl/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory
    import fetch_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_read_en,
    input  logic [NBITS-1:0] i_read_addr,   // Byte address
    input  logic             i_dbg_wr_en,
    input  logic [NBITS-1:0] i_dbg_addr,    // Byte address
    input  logic [NBITS-1:0] i_dbg_data,
    output logic [NBITS-1:0] o_data
);

    logic [NBITS-1:0]   mem [IMEM_WORDS];
    logic [IMEM_AW-1:0] read_idx;
    logic [IMEM_AW-1:0] dbg_idx;

    // Word index, byte offset dropped
    assign read_idx = i_read_addr[IMEM_AW+1:2];
    assign dbg_idx  = i_dbg_addr[IMEM_AW+1:2];

    // Program load from the debug unit
    always_ff @(posedge i_clk) begin
        if (i_dbg_wr_en) begin
            mem[dbg_idx] <= i_dbg_data;
        end
    end

    // Registered fetch read, one cycle latency
    always_ff @(posedge i_clk) begin
        if (i_read_en) begin
            o_data <= mem[read_idx];
        end
    end

endmodule

// ==== hdl/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue
    import fetch_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_flush,
    input  logic         i_push,
    input  fetch_entry_t i_push_entry,
    input  logic         i_pop,
    output logic         o_head_valid,
    output fetch_entry_t o_head,
    output logic         o_credit_return
);

    fetch_entry_t        slots [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                full;
    logic                empty;
    logic                do_push;
    logic                do_pop;

    assign full  = (count == CREDIT_W'(QUEUE_DEPTH));
    assign empty = (count == '0);

    // Flush beats both push and pop
    assign do_push = i_push && !i_flush;
    assign do_pop  = i_pop && !empty && !i_flush;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            slots[wr_ptr] <= i_push_entry;
        end
    end

    assign o_head_valid    = !empty;
    assign o_head          = slots[rd_ptr];
    assign o_credit_return = do_pop;  // One credit per pop, same cycle

    // Sequencer credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        i_push && !i_flush |-> !full);

    // Decoder only pops a visible head
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> !empty);

endmodule

// ==== hdl/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder
    import fetch_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_flush,      // Jump kills the held entry
    input  logic           i_hazard,     // Later stage stalled
    input  logic           i_head_valid,
    input  fetch_entry_t   i_head,
    output logic           o_pop,
    output logic           o_valid,
    output decoded_instr_t o_decoded
);

    decoded_instr_t dec;
    logic           release_out;
    logic [NBITS-1:0] word;

    // Outside takes the entry this cycle
    assign release_out = o_valid && !i_hazard;

    // Load when the output register is empty or draining
    assign o_pop = i_head_valid && (!o_valid || release_out) && !i_flush;

    assign word = i_head.instr;

    // MIPS field split of the queue head
    always_comb begin
        dec.pc         = i_head.pc;
        dec.instr      = word;
        dec.opcode     = word[31:26];
        dec.rs         = word[25:21];
        dec.rt         = word[20:16];
        dec.rd         = word[15:11];
        dec.shamt      = word[10:6];
        dec.funct      = word[5:0];
        dec.imm        = word[15:0];
        dec.jump_index = word[25:0];
        case (word[31:26])
            OPC_SPECIAL:   dec.kind = KIND_R;
            OPC_J,
            OPC_JAL:       dec.kind = KIND_J;
            default:       dec.kind = KIND_I;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_valid <= 1'b0;
        end else if (o_pop) begin
            o_valid <= 1'b1;
        end else if (release_out) begin
            o_valid <= 1'b0;  // Drained, nothing new
        end
    end

    // Payload only moves on a pop, so it holds through a hazard
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_decoded <= dec;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_step,             // Run enable from debug unit
    input  logic             i_pc_mux_ctrl,      // Jump select
    input  logic [NBITS-1:0] i_eff_addr,         // Jump target
    input  logic             i_inst_mem_wr_en,
    input  logic [NBITS-1:0] i_inst_mem_addr,
    input  logic [NBITS-1:0] i_inst_mem_data,
    input  logic             i_hazard_detected,
    output logic             o_valid,
    output decoded_instr_t   o_decoded,
    output logic [NBITS-1:0] o_cycle_count
);

    logic             fetch_req;
    logic [NBITS-1:0] fetch_pc;
    logic [NBITS-1:0] imem_data;
    fetch_entry_t     resp;
    logic             resp_valid;
    logic             credit_return;
    logic             head_valid;
    fetch_entry_t     head;
    logic             pop;

    pc_sequencer u_pc_sequencer (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_step          (i_step),
        .i_redirect      (i_pc_mux_ctrl),
        .i_eff_addr      (i_eff_addr),
        .i_credit_return (credit_return),
        .i_imem_data     (imem_data),
        .o_fetch_req     (fetch_req),
        .o_fetch_pc      (fetch_pc),
        .o_resp          (resp),
        .o_resp_valid    (resp_valid),
        .o_cycle_count   (o_cycle_count)
    );

    instruction_memory u_instruction_memory (
        .i_clk       (i_clk),
        .i_read_en   (fetch_req),
        .i_read_addr (fetch_pc),
        .i_dbg_wr_en (i_inst_mem_wr_en),
        .i_dbg_addr  (i_inst_mem_addr),
        .i_dbg_data  (i_inst_mem_data),
        .o_data      (imem_data)
    );

    fetch_queue u_fetch_queue (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_flush         (i_pc_mux_ctrl),
        .i_push          (resp_valid),
        .i_push_entry    (resp),
        .i_pop           (pop),
        .o_head_valid    (head_valid),
        .o_head          (head),
        .o_credit_return (credit_return)
    );

    instruction_decoder u_instruction_decoder (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_flush      (i_pc_mux_ctrl),
        .i_hazard     (i_hazard_detected),
        .i_head_valid (head_valid),
        .i_head       (head),
        .o_pop        (pop),
        .o_valid      (o_valid),
        .o_decoded    (o_decoded)
    );

endmodule

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_CYC   = 8;
    localparam int LOAD_BUDGET = RESET_CYC + IMEM_WORDS + 4;
    localparam int SEQ_COUNT   = 24;
    localparam int SEQ_BUDGET  = 3 * SEQ_COUNT;
    localparam int HAZ_CYC     = 20;
    localparam int HAZ_BUDGET  = 40;
    localparam int JUMPS       = 3;
    localparam int JUMP_BUDGET = 40;                  // Per jump
    localparam int GATE_BUDGET = 40;
    localparam int WATCHDOG_NS = (LOAD_BUDGET + SEQ_BUDGET + HAZ_CYC + HAZ_BUDGET
                                  + JUMPS * JUMP_BUDGET + 2 * GATE_BUDGET + 100) * CLK_PERIOD;
    // R, J and a few I-type opcodes
    localparam logic [5:0] OPCODES [8] = '{6'h00, 6'h00, 6'h02, 6'h08,
                                           6'h23, 6'h2b, 6'h04, 6'h0d};

    logic             i_clk = 1'b0;
    logic             i_reset;
    logic             i_step;
    logic             i_pc_mux_ctrl;
    logic [NBITS-1:0] i_eff_addr;
    logic             i_inst_mem_wr_en;
    logic [NBITS-1:0] i_inst_mem_addr;
    logic [NBITS-1:0] i_inst_mem_data;
    logic             i_hazard_detected;
    logic             o_valid;
    decoded_instr_t   o_decoded;
    logic [NBITS-1:0] o_cycle_count;

    logic [NBITS-1:0] prog [IMEM_WORDS];              // Copy of the loaded program
    logic [NBITS-1:0] rand_state = 32'd75;
    logic [NBITS-1:0] exp_pc;                         // Scoreboard PC
    decoded_instr_t   last_decoded;
    logic             accepted;
    int               accept_cnt;
    int               step_cycles;
    int               error_cnt = 0;
    int               test_cnt = 0;
    int               test_err_start = 0;

    fetch_top dut (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    function automatic logic [NBITS-1:0] lcg_next(input logic [NBITS-1:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [NBITS-1:0] program_word(input logic [NBITS-1:0] pc);
        return prog[(pc >> 2) % IMEM_WORDS];          // Memory aliases above its depth
    endfunction

    // MIPS field slices and kind rule
    function automatic decoded_instr_t split_instr(input logic [NBITS-1:0] pc,
                                                   input logic [NBITS-1:0] instr);
        decoded_instr_t d;
        d.pc         = pc;
        d.instr      = instr;
        d.opcode     = instr[31:26];
        d.rs         = instr[25:21];
        d.rt         = instr[20:16];
        d.rd         = instr[15:11];
        d.shamt      = instr[10:6];
        d.funct      = instr[5:0];
        d.imm        = instr[15:0];
        d.jump_index = instr[25:0];
        if (instr[31:26] == 6'd0) begin
            d.kind = KIND_R;
        end else if (instr[31:26] == 6'd2 || instr[31:26] == 6'd3) begin
            d.kind = KIND_J;
        end else begin
            d.kind = KIND_I;
        end
        return d;
    endfunction

    assign accepted = o_valid && !i_hazard_detected;

    // Scoreboard, accept counter and step-cycle counter
    always @(posedge i_clk) begin
        last_decoded <= o_decoded;
        if (i_reset) begin
            exp_pc      <= RESET_PC;
            accept_cnt  <= 0;
            step_cycles <= 0;
        end else begin
            if (accepted) begin
                accept_cnt <= accept_cnt + 1;
                exp_pc     <= exp_pc + PC_STEP;
            end
            if (i_pc_mux_ctrl) begin
                exp_pc <= i_eff_addr;                 // Jump overrides the step
            end
            if (i_step) begin
                step_cycles <= step_cycles + 1;
            end
        end
    end

    a_pc: assert property (@(posedge i_clk) disable iff (i_reset)
        accepted |-> o_decoded.pc == exp_pc)
        else begin
            error_cnt++;
            $display("[FAIL] o_decoded.pc: got %h, expected %h",
                     $sampled(o_decoded.pc), $sampled(exp_pc));
        end

    a_instr: assert property (@(posedge i_clk) disable iff (i_reset)
        accepted |-> o_decoded.instr == program_word(o_decoded.pc))
        else begin
            error_cnt++;
            $display("[FAIL] o_decoded.instr: got %h, expected %h",
                     $sampled(o_decoded.instr), program_word($sampled(o_decoded.pc)));
        end

    a_fields: assert property (@(posedge i_clk) disable iff (i_reset)
        accepted |-> o_decoded == split_instr(o_decoded.pc, o_decoded.instr))
        else begin
            error_cnt++;
            $display("[FAIL] o_decoded: got %h, expected %h", $sampled(o_decoded),
                     split_instr($sampled(o_decoded.pc), $sampled(o_decoded.instr)));
        end

    a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid && i_hazard_detected && !i_pc_mux_ctrl |=> o_valid && $stable(o_decoded))
        else begin
            error_cnt++;
            $display("[FAIL] o_decoded under hazard: got %h, expected %h, o_valid %h",
                     $sampled(o_decoded), $sampled(last_decoded), $sampled(o_valid));
        end

    a_cycles: assert property (@(posedge i_clk) disable iff (i_reset)
        o_cycle_count == NBITS'(step_cycles))
        else begin
            error_cnt++;
            $display("[FAIL] o_cycle_count: got %h, expected %h",
                     $sampled(o_cycle_count), NBITS'($sampled(step_cycles)));
        end

    task automatic draw_random(output logic [NBITS-1:0] value);
        rand_state = lcg_next(rand_state);
        value      = rand_state;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d (%s) finished, %0d new errors", test_cnt, name,
                 error_cnt - test_err_start);
        test_err_start = error_cnt;
    endtask

    task automatic wait_accepts(input int n, input int budget);
        int start;
        int cycles;
        start  = accept_cnt;
        cycles = 0;
        while (accept_cnt - start < n && cycles < budget) begin
            @(negedge i_clk);
            cycles++;
        end
        if (accept_cnt - start < n) begin
            error_cnt++;
            $display("Timed out after %0d cycles waiting for %0d accepted instructions",
                     budget, n);
        end
    endtask

    task automatic load_program();
        logic [NBITS-1:0] r;
        logic [NBITS-1:0] w;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            draw_random(r);
            draw_random(w);
            prog[i]          = {OPCODES[r[18:16]], w[25:0]};
            i_inst_mem_wr_en = 1'b1;
            i_inst_mem_addr  = NBITS'(i * 4);
            i_inst_mem_data  = prog[i];
            @(negedge i_clk);
        end
        i_inst_mem_wr_en = 1'b0;
        @(negedge i_clk);
        assert (!o_valid) else begin
            error_cnt++;
            $display("[FAIL] o_valid before step: got %h, expected %h", o_valid, 1'b0);
        end
    endtask

    task automatic run_hazard();
        i_hazard_detected = 1'b1;
        repeat (HAZ_CYC) @(negedge i_clk);
        // Held entry must survive the whole stall
        assert (o_valid) else begin
            error_cnt++;
            $display("[FAIL] o_valid under hazard: got %h, expected %h", o_valid, 1'b1);
        end
        i_hazard_detected = 1'b0;
        wait_accepts(8, HAZ_BUDGET);
    endtask

    task automatic run_jumps();
        logic [NBITS-1:0] r;
        for (int j = 0; j < JUMPS; j++) begin
            draw_random(r);
            if (j == 1) begin
                i_hazard_detected = 1'b1;             // Jump over a held output
                repeat (3) @(negedge i_clk);
            end
            i_pc_mux_ctrl = 1'b1;
            i_eff_addr    = NBITS'(((r >> 10) % IMEM_WORDS) * 4);
            @(negedge i_clk);
            i_pc_mux_ctrl     = 1'b0;
            i_hazard_detected = 1'b0;
            wait_accepts(6, JUMP_BUDGET);
        end
    endtask

    task automatic run_step_gate();
        int start;
        int cycles;
        int drained;
        i_step = 1'b0;
        start  = accept_cnt;
        cycles = 0;
        while (o_valid && cycles < GATE_BUDGET) begin
            @(negedge i_clk);
            cycles++;
        end
        repeat (GATE_BUDGET / 4) @(negedge i_clk);    // Quiet window
        drained = accept_cnt - start;
        assert (!o_valid && drained <= QUEUE_DEPTH + 2) else begin
            error_cnt++;
            $display("Fetch did not stop with step low: %0d outputs drained, valid still %0b",
                     drained, o_valid);
        end
        assert (o_cycle_count == NBITS'(step_cycles)) else begin
            error_cnt++;
            $display("[FAIL] o_cycle_count: got %h, expected %h", o_cycle_count, step_cycles);
        end
    endtask

    initial begin
        i_reset           = 1'b1;
        i_step            = 1'b0;
        i_pc_mux_ctrl     = 1'b0;
        i_eff_addr        = '0;
        i_inst_mem_wr_en  = 1'b0;
        i_inst_mem_addr   = '0;
        i_inst_mem_data   = '0;
        i_hazard_detected = 1'b0;
        repeat (RESET_CYC) @(negedge i_clk);
        i_reset = 1'b0;
        load_program();
        finish_test("reset and program load");
        i_step = 1'b1;
        wait_accepts(SEQ_COUNT, SEQ_BUDGET);
        finish_test("sequential fetch");
        run_hazard();
        finish_test("hazard back-pressure");
        run_jumps();
        finish_test("jump");
        run_step_gate();
        finish_test("step gating and counting");
        $display("Tests run: %0d, accepted instructions: %0d, errors: %0d",
                 test_cnt, accept_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Run limit from the test budgets
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish in its budget",
                 WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

// ==== build.f ====
hdl/fetch_pkg.sv
hdl/pc_sequencer.sv
hdl/instruction_memory.sv
hdl/fetch_queue.sv
hdl/instruction_decoder.sv
hdl/fetch_top.sv
tests/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

dependencies: {}

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/pc_sequencer.sv
      - hdl/instruction_memory.sv
      - hdl/fetch_queue.sv
      - hdl/instruction_decoder.sv
      - hdl/fetch_top.sv

  - target: test
    files:
      - tests/tb_fetch_top.sv
